/* project.f */
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/bypass_if.sv
hw/pipeline_control.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_writeback.sv
hw/pcpu_top.sv
tests/pcpu_assert.sv
tests/pcpu_tb.sv

/* Makefile */
TOP := pcpu_tb

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f project.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "*** TEST PASSED ***"

clean:
	rm -rf obj_dir

/* tests/pcpu_tb.sv */
// testbench for the pipelined cpu: random programs, asynchronous memories and an ISA model
// every store of the DUT is checked in order against the store list of the model
module pcpu_tb import isa_pkg::*, pipe_pkg::*; ();

    localparam int ADDR_W       = 8;
    localparam int MEM_WORDS    = 1 << ADDR_W;
    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_PROGS    = 24;
    localparam int BODY_LEN     = 40;
    localparam int PROG_LEN     = 2 * (REG_COUNT - 1) + BODY_LEN + REG_COUNT;
    // worst case about three advances per instruction, plus enable gaps
    localparam int TIMEOUT      = NUM_PROGS * (RESET_CYCLES + 10 + 8 * PROG_LEN) * CLK_PERIOD;

    logic              clock;
    logic              reset;
    logic              i_enable;
    logic              i_start;
    logic [DATA_W-1:0] i_i_data;
    logic [DATA_W-1:0] i_d_rdata;
    logic [ADDR_W-1:0] o_i_addr;
    logic [ADDR_W-1:0] o_d_addr;
    logic [DATA_W-1:0] o_d_wdata;
    logic              o_d_we;
    logic              o_running;

    logic [DATA_W-1:0] imem [MEM_WORDS];
    logic [DATA_W-1:0] dmem [MEM_WORDS];
    logic [DATA_W-1:0] model_mem [MEM_WORDS];
    logic [ADDR_W-1:0] exp_addr [$];
    logic [DATA_W-1:0] exp_data [$];
    logic [15:0]       lfsr;
    int                store_count;
    int                errors;

    pcpu_top #(.ADDR_W(ADDR_W)) UUT (
        .clock, .reset, .i_enable, .i_start, .i_i_data, .i_d_rdata,
        .o_i_addr, .o_d_addr, .o_d_wdata, .o_d_we, .o_running
    );

    assign i_i_data  = imem[o_i_addr];  // memories answer in the same cycle
    assign i_d_rdata = dmem[o_d_addr];

    always #(CLK_PERIOD / 2) clock = ~clock;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16 + x^14 + x^13 + x^11
    endfunction

    // one lfsr step per bit taken
    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [DATA_W-1:0] fill_word(input int a);
        return {a[7:0] ^ 8'ha5, a[7:0] + 8'h3c};
    endfunction

    function automatic logic [DATA_W-1:0] make_word(input opcode_t op, input logic [2:0] r1,
                                                    input logic [7:0] low);
        return {op, r1, low};
    endfunction

    function automatic opcode_t pick_opcode(input logic [3:0] sel, input logic [1:0] kind);
        opcode_t op;
        case (sel)
            4'd0, 4'd1: op = OPC_LOAD;
            4'd2:  op = OPC_STORE;
            4'd3:  op = OPC_SLL;
            4'd4:  op = OPC_SRL;
            4'd5:  op = OPC_ADD;
            4'd6:  op = OPC_ADDI;
            4'd7:  op = OPC_SUB;
            4'd8:  op = OPC_SUBI;
            4'd9:  op = OPC_CMP;
            4'd10: op = OPC_AND;
            4'd11: op = OPC_OR;
            4'd12: op = OPC_XOR;
            4'd13: op = OPC_LDIH;
            4'd14: op = OPC_JUMP;
            default: op = (kind == 2'd0) ? OPC_BZ : (kind == 2'd1) ? OPC_BNZ :
                          (kind == 2'd2) ? OPC_BN : OPC_BNN;
        endcase
        return op;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compare(input string name, input logic [15:0] got, input logic [15:0] want);
        if (got !== want) begin
            errors++;
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, want);
            $display("*** TEST FAILED ***");
            $fatal(1, "run stopped at the first error");
        end
    endtask

    task automatic build_program();
        logic [15:0]       bits;
        logic [15:0]       kind;
        opcode_t           op;
        logic [ADDR_W-1:0] pc;
        int                target;
        for (int a = 0; a < MEM_WORDS; a++) begin
            imem[a] = NOP_WORD;
            dmem[a] = fill_word(a);
        end
        pc = '0;
        for (int r = 1; r < REG_COUNT; r++) begin
            bits = take_bits(8);
            imem[pc] = make_word(OPC_LDIH, r[2:0], bits[7:0]);  // high byte
            pc = pc + 1'b1;
            bits = take_bits(8);
            imem[pc] = make_word(OPC_ADDI, r[2:0], bits[7:0]);  // low byte
            pc = pc + 1'b1;
        end
        for (int n = 0; n < BODY_LEN; n++) begin
            bits = take_bits(4);
            kind = take_bits(2);
            op = pick_opcode(bits[3:0], kind[1:0]);
            if (op inside {OPC_JUMP, OPC_BZ, OPC_BNZ, OPC_BN, OPC_BNN}) begin
                bits = take_bits(2);
                target = int'(pc) + 1 + int'(bits[1:0]);  // forward only, HALT at most
                if (target > PROG_LEN - 1)
                    target = PROG_LEN - 1;
                imem[pc] = make_word(op, ZERO_REG, target[7:0]);
            end else begin
                kind = take_bits(3);
                bits = take_bits(8);
                imem[pc] = make_word(op, kind[2:0], bits[7:0]);
            end
            pc = pc + 1'b1;
        end
        for (int r = 1; r < REG_COUNT; r++) begin
            imem[pc] = make_word(OPC_STORE, r[2:0], {4'd0, 4'(r)});  // r0 base, offset r
            pc = pc + 1'b1;
        end
        imem[pc] = make_word(OPC_HALT, ZERO_REG, 8'd0);
    endtask

    // sequential execution, one instruction at a time
    task automatic run_model();
        logic [DATA_W-1:0] regs [REG_COUNT];
        logic [DATA_W-1:0] word;
        logic [DATA_W-1:0] res;
        logic [DATA_W-1:0] sum;
        logic [DATA_W-1:0] jump;
        logic [ADDR_W-1:0] pc;
        logic [2:0]        r1;
        logic [2:0]        r2;
        logic [2:0]        r3;
        logic [7:0]        imm;
        logic              wr;
        logic              fl;
        logic              zf;
        logic              nf;
        logic              done;
        exp_addr.delete();
        exp_data.delete();
        for (int k = 0; k < REG_COUNT; k++)
            regs[k] = '0;
        for (int a = 0; a < MEM_WORDS; a++)
            model_mem[a] = fill_word(a);
        pc = '0;
        zf = 1'b0;
        nf = 1'b0;
        done = 1'b0;
        while (!done) begin
            word = imem[pc];
            r1 = word[10:8];
            r2 = word[6:4];
            r3 = word[2:0];
            imm = word[7:0];
            sum = regs[r2] + {12'd0, word[3:0]};  // load and store address
            jump = regs[r1] + {8'd0, imm};
            wr = 1'b0;
            fl = 1'b0;
            res = '0;
            pc = pc + 1'b1;
            case (word[15:11])
                OPC_LOAD: {wr, fl, res} = {2'b10, model_mem[sum[ADDR_W-1:0]]};
                OPC_STORE: begin
                    model_mem[sum[ADDR_W-1:0]] = regs[r1];
                    exp_addr.push_back(sum[ADDR_W-1:0]);
                    exp_data.push_back(regs[r1]);
                end
                OPC_SLL:  {wr, fl, res} = {2'b11, regs[r2] << word[3:0]};
                OPC_SRL:  {wr, fl, res} = {2'b11, regs[r2] >> word[3:0]};
                OPC_ADD:  {wr, fl, res} = {2'b11, regs[r2] + regs[r3]};
                OPC_ADDI: {wr, fl, res} = {2'b11, regs[r1] + {8'd0, imm}};
                OPC_SUB:  {wr, fl, res} = {2'b11, regs[r2] - regs[r3]};
                OPC_SUBI: {wr, fl, res} = {2'b11, regs[r1] - {8'd0, imm}};
                OPC_CMP:  {wr, fl, res} = {2'b01, regs[r2] - regs[r3]};
                OPC_AND:  {wr, fl, res} = {2'b11, regs[r2] & regs[r3]};
                OPC_OR:   {wr, fl, res} = {2'b11, regs[r2] | regs[r3]};
                OPC_XOR:  {wr, fl, res} = {2'b11, regs[r2] ^ regs[r3]};
                OPC_LDIH: {wr, fl, res} = {2'b10, imm, 8'd0};
                OPC_JUMP: pc = imm[ADDR_W-1:0];
                OPC_BZ:   pc = zf ? jump[ADDR_W-1:0] : pc;
                OPC_BNZ:  pc = !zf ? jump[ADDR_W-1:0] : pc;
                OPC_BN:   pc = nf ? jump[ADDR_W-1:0] : pc;
                OPC_BNN:  pc = !nf ? jump[ADDR_W-1:0] : pc;
                OPC_HALT: done = 1'b1;
                default: ;
            endcase
            if (wr && r1 != ZERO_REG)
                regs[r1] = res;  // r0 stays zero
            if (fl) begin
                zf = (res == '0);
                nf = res[DATA_W-1];
            end
        end
    endtask

    task automatic run_program();
        logic running_now;
        logic [15:0] bits;
        build_program();
        run_model();
        store_count = 0;
        @(posedge clock);
        reset    <= 1'b0;
        i_start  <= 1'b0;
        i_enable <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b1;
        @(posedge clock);
        compare("o_i_addr", 16'(o_i_addr), 16'd0);  // fetch starts from address 0
        i_start  <= 1'b1;
        i_enable <= 1'b1;
        @(posedge clock);
        i_start <= 1'b0;
        running_now = 1'b1;
        while (running_now) begin
            @(posedge clock);
            running_now = o_running;
            bits = take_bits(3);
            i_enable <= (bits[2:0] != 3'd0);  // low about one cycle in eight
        end
        i_enable <= 1'b1;
        compare("store count", 16'(store_count), 16'(exp_addr.size()));
        repeat (4) @(posedge clock);
        if (o_running)
            abort_run("the processor started again without a start request");
    endtask

    // store monitor, also the write port of the data memory
    always @(posedge clock) begin
        if (reset && i_enable && o_d_we) begin
            if (store_count >= exp_addr.size()) begin
                abort_run("the DUT made a store that the model does not make");
            end else begin
                compare("o_d_addr", 16'(o_d_addr), 16'(exp_addr[store_count]));
                compare("o_d_wdata", o_d_wdata, exp_data[store_count]);
                dmem[o_d_addr] = o_d_wdata;
                store_count = store_count + 1;
            end
        end
    end

    initial begin
        #(TIMEOUT);
        abort_run("watchdog expired before all programs reached HALT");
    end

    initial begin
        clock = 1'b0;
        reset    <= 1'b0;
        i_enable <= 1'b0;
        i_start  <= 1'b0;
        lfsr = 16'd36;
        errors = 0;
        store_count = 0;
        repeat (NUM_PROGS) run_program();
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("*** TEST FAILED ***");
            $fatal(1, "checks failed");
        end
    end

endmodule

/* tests/pcpu_assert.sv */
// concurrent checks on the cpu top-level ports
// attached to every pcpu_top instance by the bind at the bottom
module pcpu_assert #(
    parameter int ADDR_W = 8
) (
    input logic              clock,
    input logic              reset,
    input logic              i_enable,
    input logic [ADDR_W-1:0] o_i_addr,
    input logic              o_d_we,
    input logic              o_running
);

    // no data write unless a program runs
    assert property (@(posedge clock) disable iff (!reset) !o_running |-> !o_d_we)
        else $error("data write while the processor is idle");

    // frozen pipeline keeps its fetch address
    assert property (@(posedge clock) disable iff (!reset) !i_enable |=> $stable(o_i_addr))
        else $error("instruction address moved while enable was low");

    assert property (@(posedge clock) !reset |-> !o_d_we)
        else $error("data write during reset");

endmodule

bind pcpu_top pcpu_assert #(.ADDR_W(ADDR_W)) u_assert (
    .clock(clock),
    .reset(reset),
    .i_enable(i_enable),
    .o_i_addr(o_i_addr),
    .o_d_we(o_d_we),
    .o_running(o_running)
);

/* hw/pcpu_top.sv */
// five-stage 16-bit pipelined cpu with asynchronous instruction and data memories outside
// start runs from address 0, HALT returns to idle, low enable freezes the pipeline
module pcpu_top import isa_pkg::*, pipe_pkg::*; #(
    parameter int ADDR_W = 8
) (
    input  logic              clock,
    input  logic              reset,
    input  logic              i_enable,
    input  logic              i_start,
    input  logic [DATA_W-1:0] i_i_data,
    input  logic [DATA_W-1:0] i_d_rdata,
    output logic [ADDR_W-1:0] o_i_addr,
    output logic [ADDR_W-1:0] o_d_addr,
    output logic [DATA_W-1:0] o_d_wdata,
    output logic              o_d_we,
    output logic              o_running
);

    logic                 advance;
    logic                 stall;
    logic                 flush;
    logic                 redirect;
    logic [ADDR_W-1:0]    target;
    instr_t               id_instr;
    instr_t               ex_instr;
    instr_t               mem_instr;
    logic [DATA_W-1:0]    op_a;
    logic [DATA_W-1:0]    op_b;
    logic [DATA_W-1:0]    store_data;
    logic [DATA_W-1:0]    mem_result;
    logic [DATA_W-1:0]    mem_store_data;
    logic                 wb_we;
    logic [REG_IDX_W-1:0] wb_idx;
    logic [DATA_W-1:0]    wb_data;
    logic                 halt_done;

    bypass_if #(.DATA_W(DATA_W)) bypass ();

    pipeline_control u_control (
        .clock, .reset, .i_enable, .i_start,
        .i_halt_done(halt_done), .i_id_instr(id_instr), .i_ex_instr(ex_instr),
        .i_redirect(redirect), .o_running, .o_advance(advance),
        .o_stall(stall), .o_flush(flush)
    );

    fetch_stage #(.ADDR_W(ADDR_W)) u_fetch (
        .clock, .reset, .i_advance(advance), .i_stall(stall), .i_flush(flush),
        .i_redirect(redirect), .i_target(target), .i_i_data,
        .o_i_addr, .o_id_instr(id_instr)
    );

    decode_stage u_decode (
        .clock, .reset, .i_advance(advance), .i_stall(stall), .i_flush(flush),
        .i_id_instr(id_instr), .i_wb_we(wb_we), .i_wb_idx(wb_idx), .i_wb_data(wb_data),
        .bp(bypass.consumer), .o_ex_instr(ex_instr), .o_op_a(op_a), .o_op_b(op_b),
        .o_store_data(store_data)
    );

    execute_stage #(.ADDR_W(ADDR_W)) u_execute (
        .clock, .reset, .i_advance(advance), .i_ex_instr(ex_instr),
        .i_op_a(op_a), .i_op_b(op_b), .i_store_data(store_data),
        .bp(bypass.producer), .o_mem_instr(mem_instr), .o_mem_result(mem_result),
        .o_mem_store_data(mem_store_data), .o_redirect(redirect), .o_target(target)
    );

    memory_writeback #(.ADDR_W(ADDR_W)) u_memwb (
        .clock, .reset, .i_advance(advance), .i_mem_instr(mem_instr),
        .i_mem_result(mem_result), .i_mem_store_data(mem_store_data), .i_d_rdata,
        .bp(bypass.producer), .o_d_addr, .o_d_wdata, .o_d_we,
        .o_wb_we(wb_we), .o_wb_idx(wb_idx), .o_wb_data(wb_data), .o_halt_done(halt_done)
    );

endmodule

/* hw/memory_writeback.sv */
// data memory access, MEM/WB register and the register file write port
module memory_writeback import isa_pkg::*, pipe_pkg::*; #(
    parameter int ADDR_W = 8
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 i_advance,
    input  instr_t               i_mem_instr,
    input  logic [DATA_W-1:0]    i_mem_result,
    input  logic [DATA_W-1:0]    i_mem_store_data,
    input  logic [DATA_W-1:0]    i_d_rdata,
    bypass_if.producer           bp,
    output logic [ADDR_W-1:0]    o_d_addr,
    output logic [DATA_W-1:0]    o_d_wdata,
    output logic                 o_d_we,
    output logic                 o_wb_we,
    output logic [REG_IDX_W-1:0] o_wb_idx,
    output logic [DATA_W-1:0]    o_wb_data,
    output logic                 o_halt_done
);

    instr_t            wb_instr;
    logic [DATA_W-1:0] mem_value;

    assign o_d_addr  = i_mem_result[ADDR_W-1:0];
    assign o_d_wdata = i_mem_store_data;
    assign o_d_we    = is_store(i_mem_instr.r.opcode) && i_advance;

    // memory answers in the same cycle
    assign mem_value = is_load(i_mem_instr.r.opcode) ? i_d_rdata : i_mem_result;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wb_instr  <= NOP_WORD;
            o_wb_data <= '0;
        end else if (i_advance) begin
            wb_instr  <= i_mem_instr;
            o_wb_data <= mem_value;
        end
    end

    assign o_wb_we     = writes_reg(wb_instr.r.opcode);
    assign o_wb_idx    = wb_instr.r.r1;
    assign o_halt_done = (wb_instr.r.opcode == OPC_HALT);

    assign bp.mem_write  = writes_reg(i_mem_instr.r.opcode);
    assign bp.mem_dest   = i_mem_instr.r.r1;
    assign bp.mem_result = mem_value;
    assign bp.wb_write   = o_wb_we;
    assign bp.wb_dest    = o_wb_idx;
    assign bp.wb_result  = o_wb_data;

endmodule

/* hw/execute_stage.sv */
// ALU, zero/negative flags, branch decision and the EX/MEM register
module execute_stage import isa_pkg::*, pipe_pkg::*; #(
    parameter int ADDR_W = 8
) (
    input  logic              clock,
    input  logic              reset,
    input  logic              i_advance,
    input  instr_t            i_ex_instr,
    input  logic [DATA_W-1:0] i_op_a,
    input  logic [DATA_W-1:0] i_op_b,
    input  logic [DATA_W-1:0] i_store_data,
    bypass_if.producer        bp,
    output instr_t            o_mem_instr,
    output logic [DATA_W-1:0] o_mem_result,
    output logic [DATA_W-1:0] o_mem_store_data,
    output logic              o_redirect,
    output logic [ADDR_W-1:0] o_target
);

    opcode_t           op;
    logic [DATA_W-1:0] alu;
    logic              zf;
    logic              nf;

    assign op = i_ex_instr.r.opcode;

    always_comb begin
        case (op)
            OPC_LOAD, OPC_STORE, OPC_ADD, OPC_ADDI,
            OPC_BZ, OPC_BNZ, OPC_BN, OPC_BNN:
                alu = i_op_a + i_op_b;  // sums, addresses and branch targets
            OPC_SUB, OPC_SUBI, OPC_CMP:
                alu = i_op_a - i_op_b;
            OPC_AND:  alu = i_op_a & i_op_b;
            OPC_OR:   alu = i_op_a | i_op_b;
            OPC_XOR:  alu = i_op_a ^ i_op_b;
            OPC_SLL:  alu = i_op_a << i_op_b[3:0];
            OPC_SRL:  alu = i_op_a >> i_op_b[3:0];
            OPC_LDIH: alu = {i_op_b[7:0], {(DATA_W-8){1'b0}}};
            OPC_JUMP: alu = i_op_b;  // absolute target
            default:  alu = '0;
        endcase
    end

    // flags as left by older instructions
    always_comb begin
        case (op)
            OPC_JUMP: o_redirect = 1'b1;
            OPC_BZ:   o_redirect = zf;
            OPC_BNZ:  o_redirect = !zf;
            OPC_BN:   o_redirect = nf;
            OPC_BNN:  o_redirect = !nf;
            default:  o_redirect = 1'b0;
        endcase
    end

    assign o_target = alu[ADDR_W-1:0];

    // a load has no data yet, control stalls its user instead
    assign bp.ex_write  = writes_reg(op) && !is_load(op);
    assign bp.ex_dest   = i_ex_instr.r.r1;
    assign bp.ex_result = alu;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            zf               <= 1'b0;
            nf               <= 1'b0;
            o_mem_instr      <= NOP_WORD;
            o_mem_result     <= '0;
            o_mem_store_data <= '0;
        end else if (i_advance) begin
            if (sets_flags(op)) begin
                zf <= (alu == '0);
                nf <= alu[DATA_W-1];
            end
            o_mem_instr      <= i_ex_instr;
            o_mem_result     <= alu;
            o_mem_store_data <= i_store_data;
        end
    end

endmodule

/* hw/decode_stage.sv */
// register file, operand selection with forwarding, and the ID/EX register
module decode_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 i_advance,
    input  logic                 i_stall,
    input  logic                 i_flush,
    input  instr_t               i_id_instr,
    input  logic                 i_wb_we,
    input  logic [REG_IDX_W-1:0] i_wb_idx,
    input  logic [DATA_W-1:0]    i_wb_data,
    bypass_if.consumer           bp,
    output instr_t               o_ex_instr,
    output logic [DATA_W-1:0]    o_op_a,
    output logic [DATA_W-1:0]    o_op_b,
    output logic [DATA_W-1:0]    o_store_data
);

    logic [DATA_W-1:0] regs [REG_COUNT];
    logic [DATA_W-1:0] op_a;
    logic [DATA_W-1:0] op_b;
    logic [DATA_W-1:0] store_data;
    opcode_t           op;

    // youngest pending write wins, then the register file
    function automatic logic [DATA_W-1:0] read_src(input logic [REG_IDX_W-1:0] idx);
        if (idx == ZERO_REG)
            return '0;
        if (bp.ex_write && bp.ex_dest == idx)
            return bp.ex_result;
        if (bp.mem_write && bp.mem_dest == idx)
            return bp.mem_result;
        if (bp.wb_write && bp.wb_dest == idx)
            return bp.wb_result;
        return regs[idx];
    endfunction

    always_ff @(posedge clock) begin
        if (i_advance && i_wb_we && i_wb_idx != ZERO_REG)
            regs[i_wb_idx] <= i_wb_data;
    end

    assign op = i_id_instr.r.opcode;

    always_comb begin
        op_a = read_src(uses_r1_source(op) ? i_id_instr.r.r1 : i_id_instr.r.r2);
        if (uses_imm8(op))
            op_b = {{(DATA_W-8){1'b0}}, i_id_instr.i.imm8};
        else if (uses_r3(op))
            op_b = read_src(i_id_instr.r.r3);
        else
            op_b = {{(DATA_W-4){1'b0}}, i_id_instr.i.imm8.val3};  // offset or shift count
        store_data = read_src(i_id_instr.r.r1);
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            o_ex_instr   <= NOP_WORD;
            o_op_a       <= '0;
            o_op_b       <= '0;
            o_store_data <= '0;
        end else if (i_advance) begin
            if (i_stall || i_flush) begin
                o_ex_instr <= NOP_WORD;  // bubble into EX
            end else begin
                o_ex_instr   <= i_id_instr;
                o_op_a       <= op_a;
                o_op_b       <= op_b;
                o_store_data <= store_data;
            end
        end
    end

endmodule

/* hw/fetch_stage.sv */
// program counter and IF/ID instruction register
// stops fetching once HALT has been seen, until a redirect flushes it
module fetch_stage import isa_pkg::*; #(
    parameter int ADDR_W = 8
) (
    input  logic              clock,
    input  logic              reset,
    input  logic              i_advance,
    input  logic              i_stall,
    input  logic              i_flush,
    input  logic              i_redirect,
    input  logic [ADDR_W-1:0] i_target,
    input  instr_t            i_i_data,
    output logic [ADDR_W-1:0] o_i_addr,
    output instr_t            o_id_instr
);

    logic [ADDR_W-1:0] pc;
    logic [ADDR_W-1:0] pc_next;
    logic              halt_seen;
    logic              fetch_halt;

    assign fetch_halt = (i_i_data.r.opcode == OPC_HALT);
    assign o_i_addr   = pc;

    always_comb begin
        if (i_redirect)
            pc_next = i_target;
        else if (i_stall || halt_seen || fetch_halt)
            pc_next = pc;  // hold
        else
            pc_next = pc + 1'b1;
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            pc         <= '0;
            o_id_instr <= NOP_WORD;
            halt_seen  <= 1'b0;
        end else if (i_advance) begin
            pc <= pc_next;
            if (i_flush) begin
                o_id_instr <= NOP_WORD;  // squash the wrong-path fetch
                halt_seen  <= 1'b0;
            end else if (!i_stall) begin
                o_id_instr <= halt_seen ? NOP_WORD : i_i_data;
                halt_seen  <= halt_seen || fetch_halt;
            end
        end
    end

endmodule

/* hw/pipeline_control.sv */
// run state machine plus the load-use stall and redirect flush decisions
module pipeline_control import isa_pkg::*; (
    input  logic   clock,
    input  logic   reset,
    input  logic   i_enable,
    input  logic   i_start,
    input  logic   i_halt_done,
    input  instr_t i_id_instr,
    input  instr_t i_ex_instr,
    input  logic   i_redirect,
    output logic   o_running,
    output logic   o_advance,
    output logic   o_stall,
    output logic   o_flush
);

    typedef enum logic {IDLE, RUN} run_state_t;

    run_state_t state;
    run_state_t state_next;
    opcode_t    id_op;
    logic [2:0] load_dest;
    logic       hit_a;
    logic       hit_b;
    logic       hit_store;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state <= IDLE;
        end else if (i_enable) begin  // low enable freezes the fsm too
            state <= state_next;
        end
    end

    always_comb begin
        case (state)
            IDLE:    state_next = i_start ? RUN : IDLE;
            default: state_next = i_halt_done ? IDLE : RUN;
        endcase
    end

    assign o_running = (state == RUN);
    assign o_advance = o_running && i_enable;

    // which sources of the ID instruction hit the load destination
    assign id_op     = i_id_instr.r.opcode;
    assign load_dest = i_ex_instr.r.r1;
    assign hit_a     = load_dest == (uses_r1_source(id_op) ? i_id_instr.r.r1 : i_id_instr.r.r2);
    assign hit_b     = uses_r3(id_op) && (load_dest == i_id_instr.r.r3);
    assign hit_store = is_store(id_op) && (load_dest == i_id_instr.r.r1);

    assign o_flush = i_redirect;
    assign o_stall = is_load(i_ex_instr.r.opcode) && (load_dest != '0)
                     && (hit_a || hit_b || hit_store) && !i_redirect;

endmodule

/* hw/bypass_if.sv */
// forwarding bus carrying pending register writes from EX, MEM and WB back to decode
interface bypass_if import pipe_pkg::*; #(
    parameter int DATA_W = 16
) ();

    logic                 ex_write;
    logic [REG_IDX_W-1:0] ex_dest;
    logic [DATA_W-1:0]    ex_result;
    logic                 mem_write;
    logic [REG_IDX_W-1:0] mem_dest;
    logic [DATA_W-1:0]    mem_result;
    logic                 wb_write;
    logic [REG_IDX_W-1:0] wb_dest;
    logic [DATA_W-1:0]    wb_result;

    modport producer (
        output ex_write, ex_dest, ex_result,
        output mem_write, mem_dest, mem_result,
        output wb_write, wb_dest, wb_result
    );

    modport consumer (
        input ex_write, ex_dest, ex_result,
        input mem_write, mem_dest, mem_result,
        input wb_write, wb_dest, wb_result
    );

endinterface

/* hw/pipe_pkg.sv */
// datapath widths and register file constants shared by the pipeline stages
package pipe_pkg;

    localparam int DATA_W    = 16;
    localparam int REG_COUNT = 8;
    localparam int REG_IDX_W = 3;

    // reads as zero, writes are dropped
    localparam logic [REG_IDX_W-1:0] ZERO_REG = '0;

endpackage

/* hw/isa_pkg.sv */
// instruction set of the pipelined cpu: opcodes, the two word layouts and opcode classes
// imported by every stage that inspects an instruction word
package isa_pkg;

    typedef logic [4:0] opcode_t;

    localparam opcode_t OPC_NOP   = 5'b00000;
    localparam opcode_t OPC_HALT  = 5'b00001;
    localparam opcode_t OPC_LOAD  = 5'b00010;
    localparam opcode_t OPC_STORE = 5'b00011;
    localparam opcode_t OPC_SLL   = 5'b00100;
    localparam opcode_t OPC_SRL   = 5'b00101;
    localparam opcode_t OPC_ADD   = 5'b01000;
    localparam opcode_t OPC_ADDI  = 5'b01001;
    localparam opcode_t OPC_SUB   = 5'b01010;
    localparam opcode_t OPC_SUBI  = 5'b01011;
    localparam opcode_t OPC_CMP   = 5'b01100;
    localparam opcode_t OPC_AND   = 5'b01101;
    localparam opcode_t OPC_OR    = 5'b01110;
    localparam opcode_t OPC_XOR   = 5'b01111;
    localparam opcode_t OPC_LDIH  = 5'b10000;
    localparam opcode_t OPC_JUMP  = 5'b11000;
    localparam opcode_t OPC_BZ    = 5'b11010;
    localparam opcode_t OPC_BNZ   = 5'b11011;
    localparam opcode_t OPC_BN    = 5'b11100;
    localparam opcode_t OPC_BNN   = 5'b11101;

    // register format, spare bits sit above r2 and r3
    typedef struct packed {
        opcode_t    opcode;
        logic [2:0] r1;
        logic       spare2;
        logic [2:0] r2;
        logic       spare3;
        logic [2:0] r3;
    } r_fmt_t;

    typedef struct packed {
        logic [3:0] val2;
        logic [3:0] val3;  // shift count or load/store offset
    } imm8_t;

    typedef struct packed {
        opcode_t    opcode;
        logic [2:0] r1;
        imm8_t      imm8;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_t;

    localparam instr_t NOP_WORD = '0;

    function automatic logic is_load(opcode_t op);
        return op == OPC_LOAD;
    endfunction

    function automatic logic is_store(opcode_t op);
        return op == OPC_STORE;
    endfunction

    function automatic logic is_branch(opcode_t op);
        return op inside {OPC_JUMP, OPC_BZ, OPC_BNZ, OPC_BN, OPC_BNN};
    endfunction

    function automatic logic writes_reg(opcode_t op);
        return op inside {OPC_LOAD, OPC_LDIH, OPC_ADD, OPC_ADDI, OPC_SUB, OPC_SUBI,
                          OPC_AND, OPC_OR, OPC_XOR, OPC_SLL, OPC_SRL};
    endfunction

    function automatic logic sets_flags(opcode_t op);
        return op inside {OPC_ADD, OPC_ADDI, OPC_SUB, OPC_SUBI, OPC_CMP,
                          OPC_AND, OPC_OR, OPC_XOR, OPC_SLL, OPC_SRL};
    endfunction

    // operand a comes from r1 instead of r2
    function automatic logic uses_r1_source(opcode_t op);
        return is_branch(op) || (op inside {OPC_LDIH, OPC_ADDI, OPC_SUBI});
    endfunction

    // same group, the immediate format always pairs r1 with imm8
    function automatic logic uses_imm8(opcode_t op);
        return uses_r1_source(op);
    endfunction

    function automatic logic uses_r3(opcode_t op);
        return op inside {OPC_ADD, OPC_SUB, OPC_CMP, OPC_AND, OPC_OR, OPC_XOR};
    endfunction

endpackage
